// File: vlog.f
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_decode.sv
verilog/rv_hazard.sv
verilog/rv_stage_regs.sv
verilog/rv_execute_ctl.sv
verilog/rv_pipe_ctl_top.sv
sim/rv_clkgen.sv
sim/rv_pipe_ctl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module rv_pipe_ctl_tb \
  -o rv_pipe_ctl_sim

./obj_dir/rv_pipe_ctl_sim > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
exit 0

// File: sim/rv_pipe_ctl_tb.sv
`timescale 1ns/1ps

module rv_pipe_ctl_tb;

  // Instruction kinds the stimulus knows about
  localparam int K_OP = 0;
  localparam int K_OPIMM = 1;
  localparam int K_LOAD = 2;
  localparam int K_STORE = 3;
  localparam int K_BRANCH = 4;
  localparam int K_LUI = 5;
  localparam int K_CSR = 6;
  localparam int K_DIV = 7;
  localparam int K_JAL = 8;
  localparam int K_JALR = 9;

  // Rough cycle budget of each test
  // The run limit is twice their sum
  localparam int LEN_RESET = 8;
  localparam int LEN_INDEP = 40;
  localparam int LEN_RAW = 192;
  localparam int LEN_DIV = 180;
  localparam int LEN_JUMP = 192;
  localparam int LEN_MIX = 528;
  localparam int CYCLE_LIMIT =
    2 * (LEN_RESET + LEN_INDEP + LEN_RAW + LEN_DIV + LEN_JUMP + LEN_MIX);

  logic                  clk;
  logic                  rst_n;
  logic [31:0]           instr;
  logic                  instr_valid;
  logic                  pc_stall;
  logic [1:0]            pc_sel;
  logic                  retire_valid;
  rv_isa_pkg::reg_addr_t retire_rd;

  // Side information about the word currently presented to the DUT
  int         cur_kind;
  logic [4:0] cur_rd;
  logic [4:0] cur_rs1;
  logic [4:0] cur_rs2;

  // Reference model state
  logic [4:0] exp_mem [0:255];
  logic [7:0] wr_ptr;
  logic [7:0] rd_ptr;
  logic       exp_empty;
  logic [4:0] exp_head;
  logic       pend_valid;
  logic       pend_div;
  logic       pend_jump;
  logic       pend_need;
  logic       pend_seen;
  logic       jump_ex;
  int         div_win;
  logic       h1_wr;
  logic [4:0] h1_rd;
  int         h1_cyc;
  logic       h2_wr;
  logic [4:0] h2_rd;
  int         h2_cyc;
  logic       indep_mode;

  int          cycle_cnt;
  int          err_cnt;
  int          err_mark;
  int          tests_run;
  logic [31:0] lfsr;

  rv_clkgen u_clkgen (
    .clk(clk),
    .rst_n(rst_n)
  );

  rv_pipe_ctl_top u_dut (
    .clk(clk),
    .rst_n(rst_n),
    .instr(instr),
    .instr_valid(instr_valid),
    .pc_stall(pc_stall),
    .pc_sel(pc_sel),
    .retire_valid(retire_valid),
    .retire_rd(retire_rd)
  );

  assign exp_empty = (wr_ptr == rd_ptr);
  assign exp_head  = exp_mem[rd_ptr];

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit handed out
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Register usage straight from the base ISA formats
  function automatic logic kind_writes(input int k);
    return (k != K_STORE) && (k != K_BRANCH);
  endfunction

  function automatic logic kind_rs1(input int k);
    return (k != K_LUI) && (k != K_JAL);
  endfunction

  function automatic logic kind_rs2(input int k);
    return (k == K_OP) || (k == K_DIV) || (k == K_STORE) || (k == K_BRANCH);
  endfunction

  function automatic logic [31:0] build_word(input int k, input logic [4:0] rd,
                                             input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    case (k)
      K_OP:     return {7'd0, rs2, rs1, 3'b000, rd, rv_isa_pkg::OP_OP};
      K_DIV:    return {rv_isa_pkg::FUNCT7_MULDIV, rs2, rs1, 3'b100, rd, rv_isa_pkg::OP_OP};
      K_OPIMM:  return {12'd53, rs1, 3'b000, rd, rv_isa_pkg::OP_OP_IMM};
      K_LOAD:   return {12'd8, rs1, 3'b010, rd, rv_isa_pkg::OP_LOAD};
      K_STORE:  return {7'd0, rs2, rs1, 3'b010, 5'd4, rv_isa_pkg::OP_STORE};
      K_BRANCH: return {7'd0, rs2, rs1, 3'b000, 5'd8, rv_isa_pkg::OP_BRANCH};
      K_LUI:    return {20'h12345, rd, rv_isa_pkg::OP_LUI};
      K_CSR:    return {12'h300, rs1, 3'b001, rd, rv_isa_pkg::OP_SYSTEM};
      K_JAL:    return {20'h00100, rd, rv_isa_pkg::OP_JAL};
      default:  return {12'd0, rs1, 3'b000, rd, rv_isa_pkg::OP_JALR};
    endcase
  endfunction

  // Cycle limit so that a stuck handshake cannot hang the run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  // Reference pipeline model that updates at each rising edge from pre-edge values
  always @(posedge clk) begin : ref_model
    logic acc;
    logic moving;
    logic killed;
    logic dep;
    int   nxt_win;
    acc    = instr_valid && !pc_stall;
    moving = pend_valid && !pc_stall;
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      pend_valid <= 1'b0;
      pend_div   <= 1'b0;
      pend_jump  <= 1'b0;
      pend_need  <= 1'b0;
      pend_seen  <= 1'b0;
      jump_ex    <= 1'b0;
      div_win    <= 0;
      h1_wr      <= 1'b0;
      h2_wr      <= 1'b0;
    end else begin
      // The instruction in ID moves to EX on every edge without pc_stall
      nxt_win = (div_win != 0) ? div_win - 1 : 0;
      if (moving && pend_div) begin
        nxt_win = rv_pipe_pkg::DIV_CYCLES;
      end
      div_win <= nxt_win;
      jump_ex <= moving && pend_jump;
      if (pend_valid && pc_stall) begin
        pend_seen <= 1'b1;
      end
      if (moving) begin
        pend_valid <= 1'b0;
      end
      // Words taken while a jump enters EX and on the flush edge after it die
      killed = (moving && pend_jump) || jump_ex;
      if (acc) begin
        h2_wr  <= h1_wr;
        h2_rd  <= h1_rd;
        h2_cyc <= h1_cyc;
        h1_cyc <= cycle_cnt;
        if (killed) begin
          h1_wr <= 1'b0;
        end else begin
          // A producer one or two slots ahead still sits in EX or MEM
          dep = 1'b0;
          if (h1_wr && h1_rd != 5'd0 && h1_cyc == cycle_cnt - 1) begin
            dep = (kind_rs1(cur_kind) && cur_rs1 == h1_rd) ||
                  (kind_rs2(cur_kind) && cur_rs2 == h1_rd);
          end
          if (h2_wr && h2_rd != 5'd0 && h2_cyc == cycle_cnt - 2 &&
              h1_cyc == cycle_cnt - 1) begin
            dep = dep || (kind_rs1(cur_kind) && cur_rs1 == h2_rd) ||
                  (kind_rs2(cur_kind) && cur_rs2 == h2_rd);
          end
          h1_wr      <= kind_writes(cur_kind);
          h1_rd      <= cur_rd;
          pend_valid <= 1'b1;
          pend_div   <= (cur_kind == K_DIV);
          pend_jump  <= (cur_kind == K_JAL) || (cur_kind == K_JALR);
          pend_need  <= dep;
          pend_seen  <= 1'b0;
          if (kind_writes(cur_kind) && cur_rd != 5'd0) begin
            exp_mem[wr_ptr] <= cur_rd;
            wr_ptr          <= wr_ptr + 8'd1;
          end
        end
      end
      if (retire_valid) begin
        rd_ptr <= rd_ptr + 8'd1;
      end
    end
  end

  a_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> (!pc_stall && !retire_valid && pc_sel == rv_pipe_pkg::PC_SEL_SEQ))
  else begin
    $display("mismatch at %0t: outputs not idle in the first cycle after reset", $time);
    err_cnt = err_cnt + 1;
  end

  a_retire_order: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> (!exp_empty && retire_rd == exp_head))
  else begin
    $display("mismatch at %0t: retire_rd %0d, expected %0d (queue empty %0b)",
             $time, $sampled(retire_rd), $sampled(exp_head), $sampled(exp_empty));
    err_cnt = err_cnt + 1;
  end

  a_no_x0: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> (retire_rd != 5'd0))
  else begin
    $display("mismatch at %0t: a write to x0 retired", $time);
    err_cnt = err_cnt + 1;
  end

  a_raw_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (pend_valid && pend_need && !pc_stall) |-> pend_seen)
  else begin
    $display("mismatch at %0t: dependent instruction left ID without any stall", $time);
    err_cnt = err_cnt + 1;
  end

  a_indep: assert property (@(posedge clk) disable iff (!rst_n)
    indep_mode |-> !pc_stall)
  else begin
    $display("mismatch at %0t: pc_stall rose in an independent sequence", $time);
    err_cnt = err_cnt + 1;
  end

  a_div_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (div_win != 0) |-> pc_stall)
  else begin
    $display("mismatch at %0t: pc_stall dropped while a divide was busy", $time);
    err_cnt = err_cnt + 1;
  end

  // WB may still report its own instruction in the first busy cycle
  a_div_retire: assert property (@(posedge clk) disable iff (!rst_n)
    (div_win != 0 && div_win != rv_pipe_pkg::DIV_CYCLES) |-> !retire_valid)
  else begin
    $display("mismatch at %0t: an instruction retired while a divide was busy", $time);
    err_cnt = err_cnt + 1;
  end

  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_sel == rv_pipe_pkg::PC_SEL_REDIRECT) == jump_ex)
  else begin
    $display("mismatch at %0t: pc_sel %0d, redirect expected %0b",
             $time, $sampled(pc_sel), $sampled(jump_ex));
    err_cnt = err_cnt + 1;
  end

  // Presents one word and waits for the edge that accepts it
  task automatic send(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [4:0] rs2);
    instr       <= build_word(k, rd, rs1, rs2);
    instr_valid <= 1'b1;
    cur_kind    <= k;
    cur_rd      <= rd;
    cur_rs1     <= rs1;
    cur_rs2     <= rs2;
    @(posedge clk);
    while (pc_stall) begin
      @(posedge clk);
    end
  endtask

  // Idles the input until every expected write has retired
  task automatic drain();
    instr_valid <= 1'b0;
    @(posedge clk);
    while (!exp_empty || pend_valid || div_win != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d failed checks", name, err_cnt - err_mark);
    err_mark  = err_cnt;
    tests_run = tests_run + 1;
  endtask

  task automatic send_random(input int n, input logic with_ctl);
    logic [31:0] r;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    int          k;
    for (int i = 0; i < n; i++) begin
      rand_bits(4, r);
      rand_bits(3, rd);
      rand_bits(3, rs1);
      rand_bits(3, rs2);
      k = with_ctl ? int'(r[3:0]) % 10 : int'(r[2:0]) % 7;
      send(k, rd[4:0], rs1[4:0], rs2[4:0]);
    end
  endtask

  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] b;
    instr       = '0;
    instr_valid = 1'b0;
    cur_kind    = K_OP;
    cur_rd      = '0;
    cur_rs1     = '0;
    cur_rs2     = '0;
    indep_mode  = 1'b0;
    cycle_cnt   = 0;
    err_cnt     = 0;
    err_mark    = 0;
    tests_run   = 0;
    lfsr        = 32'he00b_5720;
    h1_cyc      = 0;
    h2_cyc      = 0;
    h1_rd       = '0;
    h2_rd       = '0;

    wait (rst_n);
    repeat (4) @(posedge clk);
    end_test("reset");

    // Sources come from x0..x15 and results go to x16..x31
    drain();
    indep_mode <= 1'b1;
    for (int i = 0; i < 24; i++) begin
      rand_bits(4, a);
      rand_bits(4, b);
      send(i % 3 == 2 ? K_LUI : i % 2, {1'b1, a[3:0]}, {1'b0, b[3:0]}, {1'b0, a[3:0]});
    end
    drain();
    indep_mode <= 1'b0;
    end_test("independent");

    send_random(48, 1'b0);
    drain();
    end_test("raw_stall");

    for (int i = 0; i < 6; i++) begin
      rand_bits(3, a);
      rand_bits(3, b);
      send(K_DIV, {2'b00, a[2:0] | 3'd1}, {2'b00, b[2:0]}, 5'd9);
      send(K_OP, 5'd10, {2'b00, a[2:0] | 3'd1}, 5'd11);
      send(K_OPIMM, 5'd12, 5'd13, 5'd0);
    end
    drain();
    end_test("divide");

    // Each jump is followed by two doomed words and one survivor
    for (int i = 0; i < 8; i++) begin
      rand_bits(3, a);
      send(i % 2 == 0 ? K_JAL : K_JALR, {2'b00, a[2:0]}, 5'd14, 5'd0);
      send_random(3, 1'b0);
    end
    drain();
    end_test("jump");

    send_random(64, 1'b1);
    send(K_OP, 5'd20, 5'd21, 5'd22);
    send(K_OP, 5'd23, 5'd24, 5'd25);
    drain();
    end_test("mixed");

    $display("tests run %0d, failed checks %0d", tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sim/rv_clkgen.sv
`timescale 1ns/1ps

module rv_clkgen (
  output logic clk,
  output logic rst_n
);

  // Free running clock with an 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset is held low for the first two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: verilog/rv_pipe_ctl_top.sv
`timescale 1ns/1ps

module rv_pipe_ctl_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [31:0]           instr,
  input  logic                  instr_valid,
  output logic                  pc_stall,
  output logic [1:0]            pc_sel,
  output logic                  retire_valid,
  output rv_isa_pkg::reg_addr_t retire_rd
);

  // IF/ID contents and their decoded register usage
  rv_isa_pkg::instr_u    instr_id;
  logic                  valid_id;
  rv_isa_pkg::reg_addr_t rs1_id;
  rv_isa_pkg::reg_addr_t rs2_id;
  rv_isa_pkg::reg_addr_t rd_id;
  logic                  rs1_used_id;
  logic                  rs2_used_id;
  logic                  reg_write_id;
  logic                  is_load_id;
  logic                  is_csr_id;
  logic                  is_div_id;
  logic                  is_jump_id;

  // Later stages as seen by the hazard unit and the execute controller
  rv_isa_pkg::reg_addr_t rd_ex;
  logic                  reg_write_ex;
  logic                  is_load_ex;
  logic                  is_csr_ex;
  logic                  is_div_ex;
  logic                  is_jump_ex;
  logic                  valid_ex;
  logic                  op_active_ex;
  rv_isa_pkg::reg_addr_t rd_mem;
  logic                  reg_write_mem;
  logic                  mem_read_mem;
  rv_isa_pkg::reg_addr_t rd_wb;
  logic                  reg_write_wb;
  logic                  valid_wb;

  // Stall and flush controls from the hazard unit
  logic                  if_id_stall;
  logic                  if_id_flush;
  logic                  id_ex_stall;
  logic                  id_ex_flush;
  logic                  ex_mem_stall;
  logic                  mem_wb_stall;

  // All ports share their names with the nets above
  rv_decode u_decode (
    .instr(instr_id),
    .*
  );

  rv_stage_regs u_stage_regs (.*);

  rv_hazard u_hazard (.*);

  rv_execute_ctl u_execute_ctl (.*);

endmodule

// File: verilog/rv_execute_ctl.sv
`timescale 1ns/1ps

module rv_execute_ctl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  valid_ex,
  input  logic                  is_div_ex,
  input  logic                  is_jump_ex,
  input  logic                  valid_wb,
  input  rv_isa_pkg::reg_addr_t rd_wb,
  input  logic                  reg_write_wb,
  output logic                  op_active_ex,
  output logic [1:0]            pc_sel,
  output logic                  retire_valid,
  output rv_isa_pkg::reg_addr_t retire_rd
);

  logic [rv_pipe_pkg::DIV_CNT_W-1:0] div_cnt;
  logic [rv_pipe_pkg::DIV_CNT_W-1:0] div_cnt_dec;
  logic                              div_done;
  logic                              div_start;
  logic                              wb_retired;

  // A divide that has not run yet starts the moment it shows up in EX
  // and counts as busy in that same cycle
  assign div_start    = valid_ex && is_div_ex && !div_done && (div_cnt == '0);
  assign op_active_ex = div_start || (div_cnt != '0);
  assign div_cnt_dec  = div_cnt - 1'b1;

  // div_done keeps the finished divide from restarting during the one
  // cycle it still sits in EX before moving on
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt  <= '0;
      div_done <= 1'b0;
    end else if (div_start) begin
      div_cnt  <= rv_pipe_pkg::DIV_LOAD;
      div_done <= (rv_pipe_pkg::DIV_CYCLES == 1);
    end else if (div_cnt != '0) begin
      div_cnt  <= div_cnt_dec;
      div_done <= (div_cnt_dec == '0);
    end else begin
      div_done <= 1'b0;
    end
  end

  // Jumps are resolved in EX and always taken
  assign pc_sel = (valid_ex && is_jump_ex) ? rv_pipe_pkg::PC_SEL_REDIRECT
                                           : rv_pipe_pkg::PC_SEL_SEQ;

  // WB is frozen along with the rest during a divide, so remember that the
  // held instruction was already reported
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_retired <= 1'b0;
    end else begin
      wb_retired <= op_active_ex && (wb_retired || retire_valid);
    end
  end

  // Writes to x0 are discarded by the register file and never retire
  assign retire_valid = valid_wb && reg_write_wb && (rd_wb != '0) && !wb_retired;
  assign retire_rd    = rd_wb;

endmodule

// File: verilog/rv_stage_regs.sv
`timescale 1ns/1ps

module rv_stage_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [31:0]           instr,
  input  logic                  instr_valid,
  input  rv_isa_pkg::reg_addr_t rd_id,
  input  logic                  reg_write_id,
  input  logic                  is_load_id,
  input  logic                  is_csr_id,
  input  logic                  is_div_id,
  input  logic                  is_jump_id,
  input  logic                  pc_stall,
  input  logic                  if_id_stall,
  input  logic                  if_id_flush,
  input  logic                  id_ex_stall,
  input  logic                  id_ex_flush,
  input  logic                  ex_mem_stall,
  input  logic                  mem_wb_stall,
  output rv_isa_pkg::instr_u    instr_id,
  output logic                  valid_id,
  output rv_isa_pkg::reg_addr_t rd_ex,
  output logic                  reg_write_ex,
  output logic                  is_load_ex,
  output logic                  is_csr_ex,
  output logic                  is_div_ex,
  output logic                  is_jump_ex,
  output logic                  valid_ex,
  output rv_isa_pkg::reg_addr_t rd_mem,
  output logic                  reg_write_mem,
  output logic                  mem_read_mem,
  output rv_isa_pkg::reg_addr_t rd_wb,
  output logic                  reg_write_wb,
  output logic                  valid_wb
);

  logic valid_mem;
  logic take_instr;

  // The source holds its word while pc_stall is high, so only a free IF/ID
  // with the front end running accepts a new instruction
  assign take_instr = !if_id_stall && !pc_stall;

  // Every stage resolves flush first, then stall, then advance
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_id      <= 1'b0;
      valid_ex      <= 1'b0;
      reg_write_ex  <= 1'b0;
      is_load_ex    <= 1'b0;
      is_csr_ex     <= 1'b0;
      is_div_ex     <= 1'b0;
      is_jump_ex    <= 1'b0;
      valid_mem     <= 1'b0;
      reg_write_mem <= 1'b0;
      mem_read_mem  <= 1'b0;
      valid_wb      <= 1'b0;
      reg_write_wb  <= 1'b0;
    end else begin
      if (if_id_flush) begin
        valid_id <= 1'b0;
      end else if (!if_id_stall) begin
        valid_id <= instr_valid && !pc_stall;
      end

      // The decoder already drops its flags for an empty ID slot, so a
      // cleared valid and cleared flags always travel together into EX
      if (id_ex_flush) begin
        valid_ex     <= 1'b0;
        reg_write_ex <= 1'b0;
        is_load_ex   <= 1'b0;
        is_csr_ex    <= 1'b0;
        is_div_ex    <= 1'b0;
        is_jump_ex   <= 1'b0;
      end else if (!id_ex_stall) begin
        valid_ex     <= valid_id;
        reg_write_ex <= reg_write_id;
        is_load_ex   <= is_load_id;
        is_csr_ex    <= is_csr_id;
        is_div_ex    <= is_div_id;
        is_jump_ex   <= is_jump_id;
      end

      // EX/MEM has no flush of its own; the bubble left behind by an
      // ID/EX flush reaches it one edge later
      if (!ex_mem_stall) begin
        valid_mem     <= valid_ex;
        reg_write_mem <= reg_write_ex;
        mem_read_mem  <= is_load_ex;
      end

      if (!mem_wb_stall) begin
        valid_wb     <= valid_mem;
        reg_write_wb <= reg_write_mem;
      end
    end
  end

  // Word and destination indices follow the same advance conditions
  always_ff @(posedge clk) begin
    if (take_instr) begin
      instr_id <= instr;
    end
    if (!id_ex_stall) begin
      rd_ex <= rd_id;
    end
    if (!ex_mem_stall) begin
      rd_mem <= rd_ex;
    end
    if (!mem_wb_stall) begin
      rd_wb <= rd_mem;
    end
  end

endmodule

// File: verilog/rv_hazard.sv
`timescale 1ns/1ps

module rv_hazard #(
  parameter int FWD         = rv_pipe_pkg::FWD_DEFAULT,
  parameter int FWD_REGFILE = rv_pipe_pkg::FWD_REGFILE_DEFAULT,
  parameter int MEM_TYPE    = rv_pipe_pkg::MEM_TYPE_BRAM
) (
  input  rv_isa_pkg::reg_addr_t rs1_id,
  input  rv_isa_pkg::reg_addr_t rs2_id,
  input  logic                  rs1_used_id,
  input  logic                  rs2_used_id,
  input  rv_isa_pkg::reg_addr_t rd_ex,
  input  logic                  reg_write_ex,
  input  logic                  is_load_ex,
  input  logic                  is_csr_ex,
  input  logic                  op_active_ex,
  input  rv_isa_pkg::reg_addr_t rd_mem,
  input  logic                  reg_write_mem,
  input  logic                  mem_read_mem,
  input  rv_isa_pkg::reg_addr_t rd_wb,
  input  logic                  reg_write_wb,
  input  logic [1:0]            pc_sel,
  output logic                  pc_stall,
  output logic                  if_id_stall,
  output logic                  if_id_flush,
  output logic                  id_ex_stall,
  output logic                  id_ex_flush,
  output logic                  ex_mem_stall,
  output logic                  mem_wb_stall
);

  logic ex_hit;
  logic mem_hit;
  logic wb_hit;
  logic mem_producer;
  logic data_hazard;
  logic redirect;
  logic front_stall;

  // True when a used source matches a pending write, x0 never counts
  function automatic logic src_hit(
    input rv_isa_pkg::reg_addr_t rs,
    input logic                  used,
    input rv_isa_pkg::reg_addr_t rd,
    input logic                  we
  );
    return used && we && (rd != '0) && (rd == rs);
  endfunction

  // The instruction in ID against the one directly ahead of it in EX
  assign ex_hit = src_hit(rs1_id, rs1_used_id, rd_ex, reg_write_ex) ||
                  src_hit(rs2_id, rs2_used_id, rd_ex, reg_write_ex);

  // A load in MEM always lands in rd, so its read strobe marks a pending write too
  assign mem_producer = reg_write_mem || mem_read_mem;
  assign mem_hit = src_hit(rs1_id, rs1_used_id, rd_mem, mem_producer) ||
                   src_hit(rs2_id, rs2_used_id, rd_mem, mem_producer);

  // WB only matters when the register file cannot hand a same-cycle write
  // straight to the read port
  if (FWD_REGFILE == 0) begin : g_wb_check
    assign wb_hit = src_hit(rs1_id, rs1_used_id, rd_wb, reg_write_wb) ||
                    src_hit(rs2_id, rs2_used_id, rd_wb, reg_write_wb);
  end else begin : g_wb_bypass
    assign wb_hit = 1'b0;
  end

  if (FWD != 0) begin : g_fwd
    logic late_result_ex;

    // With a forwarding unit only results that do not exist yet must wait
    // CSR reads finish in WB, BRAM loads one cycle after MEM
    if (MEM_TYPE == rv_pipe_pkg::MEM_TYPE_SRAM) begin : g_sram
      assign late_result_ex = is_csr_ex;
    end else begin : g_bram
      assign late_result_ex = is_load_ex || is_csr_ex;
    end

    assign data_hazard = (late_result_ex && ex_hit) || wb_hit;
  end else begin : g_no_fwd
    // Without forwarding every in-flight producer holds the consumer in ID
    assign data_hazard = ex_hit || mem_hit || wb_hit;
  end

  assign redirect = (pc_sel == rv_pipe_pkg::PC_SEL_REDIRECT);

  // The instruction in ID is discarded on a redirect, so its hazard is moot
  // and the front end must keep moving to pick up the new path
  assign front_stall = (data_hazard || op_active_ex) && !redirect;

  assign pc_stall    = front_stall;
  assign if_id_stall = front_stall;

  // A busy divide freezes everything from EX onward
  assign id_ex_stall  = op_active_ex;
  assign ex_mem_stall = op_active_ex;
  assign mem_wb_stall = op_active_ex;

  // Data hazards send a bubble into EX, except while EX is frozen by a divide
  assign if_id_flush = redirect;
  assign id_ex_flush = (data_hazard && !op_active_ex) || redirect;

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_isa_pkg::instr_u    instr,
  input  logic                  valid_id,
  output rv_isa_pkg::reg_addr_t rs1_id,
  output rv_isa_pkg::reg_addr_t rs2_id,
  output rv_isa_pkg::reg_addr_t rd_id,
  output logic                  rs1_used_id,
  output logic                  rs2_used_id,
  output logic                  reg_write_id,
  output logic                  is_load_id,
  output logic                  is_csr_id,
  output logic                  is_div_id,
  output logic                  is_jump_id
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       uses_rs1;
  logic       uses_rs2;
  logic       writes_rd;
  logic       load_op;
  logic       csr_op;
  logic       div_op;
  logic       jump_op;

  // Register indices sit in the same bits for every format, so take them
  // from the register-register view even when the format has an immediate
  assign rs1_id = instr.r.rs1;
  assign rs2_id = instr.r.rs2;
  assign rd_id  = instr.r.rd;

  // Opcode and function bits come through the immediate view
  assign opcode = instr.i.opcode;
  assign funct3 = instr.i.funct3;
  assign funct7 = instr.i.imm_hi;

  always_comb begin
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    writes_rd = 1'b0;
    load_op   = 1'b0;
    csr_op    = 1'b0;
    div_op    = 1'b0;
    jump_op   = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_LOAD: begin
        uses_rs1  = 1'b1;
        writes_rd = 1'b1;
        load_op   = 1'b1;
      end
      // Stores and branches read both sources and write nothing back
      rv_isa_pkg::OP_STORE, rv_isa_pkg::OP_BRANCH: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      rv_isa_pkg::OP_OP: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        writes_rd = 1'b1;
        // Only the divide and remainder half of the M extension is multi-cycle
        div_op    = (funct7 == rv_isa_pkg::FUNCT7_MULDIV) &&
                    (funct3 >= rv_isa_pkg::FUNCT3_DIV_MIN);
      end
      rv_isa_pkg::OP_OP_IMM: begin
        uses_rs1  = 1'b1;
        writes_rd = 1'b1;
      end
      // JAL and LUI read no register at all
      rv_isa_pkg::OP_JAL: begin
        writes_rd = 1'b1;
        jump_op   = 1'b1;
      end
      rv_isa_pkg::OP_JALR: begin
        uses_rs1  = 1'b1;
        writes_rd = 1'b1;
        jump_op   = 1'b1;
      end
      rv_isa_pkg::OP_LUI: begin
        writes_rd = 1'b1;
      end
      rv_isa_pkg::OP_SYSTEM: begin
        // funct3 of zero is ECALL, EBREAK and friends, which touch no register
        // The immediate CSR forms put a zimm where rs1 would be
        if (funct3 != 3'd0) begin
          uses_rs1  = !funct3[2];
          writes_rd = 1'b1;
          csr_op    = 1'b1;
        end
      end
      default: begin
        uses_rs1 = 1'b0;
      end
    endcase
  end

  // An empty IF/ID slot must look like a bubble to the hazard unit
  assign rs1_used_id  = valid_id && uses_rs1;
  assign rs2_used_id  = valid_id && uses_rs2;
  assign reg_write_id = valid_id && writes_rd;
  assign is_load_id   = valid_id && load_op;
  assign is_csr_id    = valid_id && csr_op;
  assign is_div_id    = valid_id && div_op;
  assign is_jump_id   = valid_id && jump_op;

endmodule

// File: verilog/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // Next PC source as reported by the EX stage
  localparam logic [1:0] PC_SEL_SEQ      = 2'b00;
  localparam logic [1:0] PC_SEL_REDIRECT = 2'b01;

  // Data memory flavour behind the MEM stage
  // SRAM returns load data in MEM, BRAM only one cycle later
  localparam int MEM_TYPE_SRAM = 0;
  localparam int MEM_TYPE_BRAM = 1;

  // Default hazard policy: no forwarding unit, register file bypasses WB
  localparam int FWD_DEFAULT         = 0;
  localparam int FWD_REGFILE_DEFAULT = 1;

  // Number of cycles a divide keeps the EX stage busy
  localparam int DIV_CYCLES = 4;

  // Busy counter sizing and the value it loads on a new divide
  localparam int DIV_CNT_W = $clog2(DIV_CYCLES + 1);
  localparam logic [DIV_CNT_W-1:0] DIV_LOAD = DIV_CNT_W'(DIV_CYCLES - 1);

endpackage

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  // Width of an integer register index, x0 to x31
  localparam int REG_ADDR_W = 5;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes this control slice tells apart
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;

  // M extension marker in funct7 of an OP instruction
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // From this funct3 upward the M extension op is DIV, DIVU, REM or REMU
  localparam logic [2:0] FUNCT3_DIV_MIN = 3'd4;

  // Register-register layout, used for the register index fields
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Immediate and store layout where the same bit ranges carry immediate bits
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2_or_imm_lo;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] rd_or_imm;
    logic [6:0] opcode;
  } is_fmt_t;

  typedef union packed {
    r_fmt_t  r;
    is_fmt_t i;
  } instr_u;

endpackage
